//--- logic/spi_reg_pkg.sv
`default_nettype none

package spi_reg_pkg;

  localparam int CMD_WIDTH   = 12;
  localparam int ADDR_WIDTH  = 3;
  localparam int DATA_WIDTH  = 8;
  localparam int HDR_WIDTH   = 4; // rw bit plus the address.
  localparam int SCLK_HALF   = 4;
  localparam int RD_GAP      = 16;
  localparam int QUEUE_DEPTH = 4;

  // counter widths derived from the sizes above.
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam int SCLK_CNT_W  = $clog2(SCLK_HALF);
  localparam int BIT_CNT_W   = $clog2(CMD_WIDTH + 1);
  localparam int GAP_CNT_W   = $clog2(RD_GAP);

  // Command word as sent on the wire, MSB first.
  typedef struct packed {
    logic                  rw;   // 1 selects a register write.
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
  } spi_cmd_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    W_SHIFT,
    R_HDR,
    R_GAP,
    R_DATA,
    DONE
  } frame_state_e;

endpackage

`default_nettype wire

//--- logic/spi_cmd_queue.sv
`default_nettype none

module spi_cmd_queue
  import spi_reg_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  spi_cmd_t push_cmd,
  input  logic     pop,
  output logic     full,
  output spi_cmd_t head,
  output logic     valid
);

  spi_cmd_t               mem [QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wr_ptr;
  logic [QUEUE_PTR_W-1:0] rd_ptr;
  logic [QUEUE_CNT_W-1:0] count;
  logic                   do_push;
  logic                   do_pop;

  assign full    = (count == QUEUE_CNT_W'(QUEUE_DEPTH));
  assign valid   = (count != '0);
  assign head    = mem[rd_ptr];
  assign do_push = push && !full; // a push while full is dropped.
  assign do_pop  = pop && valid;

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= push_cmd;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= wr_ptr + 1'b1; // depth is a power of two so the pointer wraps.
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the engine only pops after it has seen valid.
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n) pop |-> valid
  ) else $error("command queue popped while empty");

  a_count_bound: assert property (
    @(posedge clk) disable iff (!rst_n) count <= QUEUE_CNT_W'(QUEUE_DEPTH)
  ) else $error("command queue count above depth");

endmodule

`default_nettype wire

//--- logic/spi_sclk_gen.sv
`default_nettype none

module spi_sclk_gen
  import spi_reg_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic sclk,
  output logic rise,
  output logic fall
);

  logic [SCLK_CNT_W-1:0] half_cnt;
  logic                  toggle;

  // a toggle ends every half period while the phase runs.
  assign toggle = run && (half_cnt == SCLK_CNT_W'(SCLK_HALF - 1));

  // pulses line up with the clock edge that moves sclk.
  assign rise = toggle && !sclk;
  assign fall = toggle && sclk;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      half_cnt <= '0;
      sclk     <= 1'b0;
    end
    else if (!run)
    begin
      half_cnt <= '0; // next phase starts with a full low half.
      sclk     <= 1'b0;
    end
    else if (toggle)
    begin
      half_cnt <= '0;
      sclk     <= ~sclk;
    end
    else
    begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  a_edges_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(rise && fall)
  ) else $error("sclk rise and fall pulsed together");

endmodule

`default_nettype wire

//--- logic/spi_frame_engine.sv
`default_nettype none

module spi_frame_engine
  import spi_reg_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  q_valid,
  input  spi_cmd_t              q_cmd,
  input  logic                  sclk_rise,
  input  logic                  sclk_fall,
  input  logic                  miso,
  output logic                  q_pop,
  output logic                  sclk_run,
  output logic                  cs_n,
  output logic                  mosi,
  output logic                  read_vld,
  output logic [DATA_WIDTH-1:0] read_data
);

  frame_state_e           state;
  frame_state_e           state_nxt;
  spi_cmd_t               cmd_q;
  logic [CMD_WIDTH-1:0]   tx_sreg;
  logic [DATA_WIDTH-1:0]  rx_sreg;
  logic [BIT_CNT_W-1:0]   bit_cnt;
  logic [BIT_CNT_W-1:0]   bit_last;
  logic [GAP_CNT_W-1:0]   gap_cnt;
  logic                   shifting;
  logic                   tx_phase;
  logic                   phase_done;

  assign shifting = (state == W_SHIFT) || (state == R_HDR) || (state == R_DATA);
  assign tx_phase = (state == W_SHIFT) || (state == R_HDR);
  assign sclk_run = shifting;
  assign q_pop    = (state == IDLE) && q_valid;

  // number of the final bit in the current shift phase.
  always_comb
  begin
    case (state)
      W_SHIFT: bit_last = BIT_CNT_W'(CMD_WIDTH - 1);
      R_HDR:   bit_last = BIT_CNT_W'(HDR_WIDTH - 1);
      default: bit_last = BIT_CNT_W'(DATA_WIDTH - 1);
    endcase
  end

  // a phase ends on the falling edge that closes its last bit.
  assign phase_done = shifting && sclk_fall && (bit_cnt == bit_last);

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
      begin
        if (q_valid)
        begin
          state_nxt = LOAD;
        end
      end
      LOAD:
      begin
        state_nxt = cmd_q.rw ? W_SHIFT : R_HDR;
      end
      W_SHIFT:
      begin
        if (phase_done)
        begin
          state_nxt = DONE;
        end
      end
      R_HDR:
      begin
        if (phase_done)
        begin
          state_nxt = R_GAP;
        end
      end
      R_GAP:
      begin
        if (gap_cnt == GAP_CNT_W'(RD_GAP - 1))
        begin
          state_nxt = R_DATA;
        end
      end
      R_DATA:
      begin
        if (phase_done)
        begin
          state_nxt = DONE;
        end
      end
      DONE:
      begin
        state_nxt = IDLE;
      end
      default:
      begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      cs_n     <= 1'b1;
      mosi     <= 1'b0;
      read_vld <= 1'b0;
      bit_cnt  <= '0;
      gap_cnt  <= '0;
    end
    else
    begin
      state <= state_nxt;
      // chip select is low for exactly the shift states.
      cs_n  <= !((state_nxt == W_SHIFT) || (state_nxt == R_HDR) || (state_nxt == R_DATA));
      read_vld <= (state == R_DATA) && (state_nxt == DONE);

      if (state_nxt != state)
      begin
        bit_cnt <= '0;
      end
      else if (shifting && sclk_fall)
      begin
        bit_cnt <= bit_cnt + 1'b1;
      end

      if (state == R_GAP)
      begin
        gap_cnt <= gap_cnt + 1'b1;
      end
      else
      begin
        gap_cnt <= '0;
      end

      if (state == LOAD)
      begin
        mosi <= cmd_q.rw; // first bit is valid before the first rising edge.
      end
      else if (tx_phase && sclk_fall)
      begin
        mosi <= phase_done ? 1'b0 : tx_sreg[CMD_WIDTH-1];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (q_pop)
    begin
      cmd_q <= q_cmd;
    end
    if (state == LOAD)
    begin
      tx_sreg <= {cmd_q[CMD_WIDTH-2:0], 1'b0}; // the MSB is already on mosi.
    end
    else if (tx_phase && sclk_fall)
    begin
      tx_sreg <= {tx_sreg[CMD_WIDTH-2:0], 1'b0};
    end
    if ((state == R_DATA) && sclk_rise)
    begin
      rx_sreg <= {rx_sreg[DATA_WIDTH-2:0], miso};
    end
    if ((state == R_DATA) && phase_done)
    begin
      read_data <= rx_sreg;
    end
  end

  a_idle_cs_high: assert property (
    @(posedge clk) disable iff (!rst_n) (state == IDLE) |-> cs_n
  ) else $error("cs_n low while engine idle");

  // a result only follows a read command.
  a_no_vld_after_write: assert property (
    @(posedge clk) disable iff (!rst_n) read_vld |-> !cmd_q.rw
  ) else $error("read_vld pulsed outside a read frame");

endmodule

`default_nettype wire

//--- logic/spi_reg_bridge.sv
`default_nettype none

module spi_reg_bridge
  import spi_reg_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_vld,
  input  spi_cmd_t              cmd_in,
  input  logic                  miso,
  output logic                  cmd_rdy,
  output logic                  sclk,
  output logic                  cs_n,
  output logic                  mosi,
  output logic                  read_vld,
  output logic [DATA_WIDTH-1:0] read_data
);

  spi_cmd_t q_cmd;
  logic     q_valid;
  logic     q_pop;
  logic     q_full;
  logic     sclk_run;
  logic     sclk_rise;
  logic     sclk_fall;

  assign cmd_rdy = ~q_full;

  spi_cmd_queue u_queue (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (cmd_vld),
    .push_cmd (cmd_in),
    .pop      (q_pop),
    .full     (q_full),
    .head     (q_cmd),
    .valid    (q_valid)
  );

  spi_sclk_gen u_sclk_gen (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (sclk_run),
    .sclk  (sclk),
    .rise  (sclk_rise),
    .fall  (sclk_fall)
  );

  spi_frame_engine u_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .q_valid   (q_valid),
    .q_cmd     (q_cmd),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall),
    .miso      (miso),
    .q_pop     (q_pop),
    .sclk_run  (sclk_run),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  // the serial clock may only pulse inside a chip-select window.
  a_sclk_in_frame: assert property (
    @(posedge clk) disable iff (!rst_n) sclk |-> !cs_n
  ) else $error("sclk high while cs_n deasserted");

endmodule

`default_nettype wire

//--- verif/spi_reg_checker.sv
`default_nettype none

module spi_reg_checker
  import spi_reg_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_vld,
  input  logic                  cmd_rdy,
  input  spi_cmd_t              cmd_in,
  input  logic                  cs_n,
  input  logic                  sclk,
  input  logic                  mosi,
  input  logic                  read_vld,
  input  logic [DATA_WIDTH-1:0] read_data,
  input  logic                  test_end,
  output int                    n_pass,
  output int                    n_fail,
  output int                    n_done,
  output logic                  closed
);

  spi_cmd_t              exp_q [$];
  spi_cmd_t              exp;
  spi_cmd_t              bits;
  logic [DATA_WIDTH-1:0] shadow [2**ADDR_WIDTH];
  logic [ADDR_WIDTH-1:0] rd_addr;
  int                    nbits;
  int                    high_len;
  logic                  cs_q;
  logic                  sclk_q;
  logic                  in_read;
  logic                  data_seen;
  logic                  full_seen;
  logic                  reset_seen;
  logic                  ok;

  task automatic compare(input string sig, input logic [CMD_WIDTH-1:0] want,
                         input logic [CMD_WIDTH-1:0] got, inout logic pass);
    if (want !== got)
    begin
      $display("FAIL t=%0t %s expected=%h got=%h", $time, sig, want, got);
      pass = 1'b0;
    end
  endtask

  task automatic close_test(input logic pass, input string what);
    if (pass)
    begin
      n_pass++;
      $display("done: %s ok", what);
    end
    else
    begin
      n_fail++;
      $display("done: %s with errors", what);
    end
  endtask

  task automatic report_error(input string what);
    $display("ERROR t=%0t %s", $time, what);
    n_fail++;
  endtask

  // a frame ends when cs_n rises. The bit count tells its kind.
  task automatic end_frame();
    if (exp_q.size() == 0)
    begin
      report_error("a frame appeared with no accepted command");
    end
    else if (nbits == CMD_WIDTH)
    begin
      exp = exp_q.pop_front();
      ok = exp.rw;
      compare("mosi", CMD_WIDTH'(exp), CMD_WIDTH'(bits), ok);
      if (exp.rw)
      begin
        shadow[exp.addr] = exp.data;
      end
      n_done++;
      close_test(ok, $sformatf("write addr=%0d data=%h", bits.addr, bits.data));
    end
    else if (nbits == HDR_WIDTH && !in_read)
    begin
      exp = exp_q[0];
      ok = 1'b1;
      compare("mosi", CMD_WIDTH'({exp.rw, exp.addr}), CMD_WIDTH'(bits[HDR_WIDTH-1:0]), ok);
      if (!ok)
      begin
        n_fail++;
      end
      in_read = 1'b1;
      data_seen = 1'b0;
      rd_addr = bits[ADDR_WIDTH-1:0];
    end
    else if (nbits == DATA_WIDTH && in_read)
    begin
      data_seen = 1'b1;
    end
    else
    begin
      report_error($sformatf("a frame carried %0d bits, which fits no command", nbits));
    end
  endtask

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      exp_q.delete();
      foreach (shadow[i])
        shadow[i] = '0;
      {nbits, high_len, n_pass, n_fail, n_done} = '0;
      {in_read, data_seen, full_seen, reset_seen, closed, sclk_q} = '0;
      cs_q = 1'b1;
    end
    else
    begin
      if (!reset_seen)
      begin
        ok = 1'b1;
        compare("cs_n", CMD_WIDTH'(1'b1), CMD_WIDTH'(cs_n), ok);
        compare("sclk", CMD_WIDTH'(1'b0), CMD_WIDTH'(sclk), ok);
        compare("mosi", CMD_WIDTH'(1'b0), CMD_WIDTH'(mosi), ok);
        compare("read_vld", CMD_WIDTH'(1'b0), CMD_WIDTH'(read_vld), ok);
        compare("cmd_rdy", CMD_WIDTH'(1'b1), CMD_WIDTH'(cmd_rdy), ok);
        close_test(ok, "reset values");
        reset_seen = 1'b1;
      end
      if (cmd_vld && cmd_rdy)
      begin
        exp_q.push_back(cmd_in);
      end
      full_seen = full_seen || !cmd_rdy;
      if (cs_n)
      begin
        high_len++;
      end
      if (cs_q && !cs_n)
      begin
        nbits = 0;
        if (in_read && !data_seen)
        begin
          ok = 1'b1;
          compare("cs_n gap", CMD_WIDTH'(RD_GAP), CMD_WIDTH'(high_len), ok);
          if (!ok)
          begin
            n_fail++;
          end
        end
        high_len = 0;
      end
      if (!sclk_q && sclk && !cs_n)
      begin
        bits = {bits[CMD_WIDTH-2:0], mosi}; // mosi is stable while sclk is high.
        nbits++;
      end
      if (!cs_q && cs_n)
      begin
        end_frame();
      end
      if (read_vld)
      begin
        if (!in_read || !data_seen)
        begin
          report_error("read_vld pulsed outside a read frame");
        end
        else
        begin
          void'(exp_q.pop_front());
          ok = 1'b1;
          compare("read_data", CMD_WIDTH'(shadow[rd_addr]), CMD_WIDTH'(read_data), ok);
          n_done++;
          in_read = 1'b0;
          close_test(ok, $sformatf("read addr=%0d data=%h", rd_addr, read_data));
        end
      end
      if (test_end && !closed)
      begin
        if (exp_q.size() != 0 || in_read)
        begin
          report_error("accepted commands never completed as frames");
        end
        ok = full_seen;
        close_test(ok, "cmd_rdy back-pressure during burst");
        closed = 1'b1;
      end
      cs_q = cs_n;
      sclk_q = sclk;
    end
  end

endmodule

`default_nettype wire

//--- verif/spi_reg_bridge_tb.sv
`default_nettype none

module spi_reg_bridge_tb
  import spi_reg_pkg::*;
();

  typedef struct packed {
    logic                  rw;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    logic                  rnd;   // take the data byte from the LFSR.
    logic                  burst; // keep cmd_vld high into the next entry.
  } stim_t;

  localparam int N_STIM        = 16;
  localparam int RDY_TIMEOUT   = 1000;
  localparam int FRAME_TIMEOUT = 5000;

  // rw, addr, data, rnd, burst.
  stim_t stim_tab [N_STIM] = '{
    '{1'b0, 3'd2, 8'h00, 1'b0, 1'b0}, '{1'b1, 3'd2, 8'ha5, 1'b0, 1'b0},
    '{1'b0, 3'd2, 8'h00, 1'b0, 1'b0}, '{1'b0, 3'd5, 8'h00, 1'b0, 1'b0},
    '{1'b1, 3'd7, 8'h00, 1'b1, 1'b0}, '{1'b0, 3'd7, 8'h00, 1'b0, 1'b0},
    '{1'b1, 3'd0, 8'h00, 1'b1, 1'b0}, '{1'b0, 3'd2, 8'h00, 1'b0, 1'b0},
    '{1'b1, 3'd1, 8'h00, 1'b1, 1'b1}, '{1'b1, 3'd3, 8'h00, 1'b1, 1'b1},
    '{1'b0, 3'd1, 8'h00, 1'b0, 1'b1}, '{1'b1, 3'd1, 8'h3c, 1'b0, 1'b1},
    '{1'b0, 3'd1, 8'h00, 1'b0, 1'b1}, '{1'b0, 3'd3, 8'h00, 1'b0, 1'b1},
    '{1'b1, 3'd4, 8'h00, 1'b1, 1'b1}, '{1'b0, 3'd4, 8'h00, 1'b0, 1'b0}
  };

  logic                  clk;
  logic                  rst_n;
  logic                  cmd_vld;
  spi_cmd_t              cmd_in;
  logic                  miso = 1'b0;
  logic                  cmd_rdy;
  logic                  sclk;
  logic                  cs_n;
  logic                  mosi;
  logic                  read_vld;
  logic [DATA_WIDTH-1:0] read_data;
  logic                  test_end;
  logic                  closed;
  logic                  hung;
  logic [31:0]           lfsr_state;
  int                    n_pass;
  int                    n_fail;
  int                    n_done;
  int                    sent;

  spi_cmd_t              slave_rx;
  logic [DATA_WIDTH-1:0] slave_regs [2**ADDR_WIDTH];
  logic [DATA_WIDTH-1:0] slave_tx;
  logic [ADDR_WIDTH-1:0] slave_addr;
  int                    slave_bits;
  logic                  slave_cs_q;
  logic                  slave_sclk_q;
  logic                  slave_pend;
  logic                  slave_data;

  spi_reg_bridge DUT (
    .clk(clk), .rst_n(rst_n), .cmd_vld(cmd_vld), .cmd_in(cmd_in), .miso(miso),
    .cmd_rdy(cmd_rdy), .sclk(sclk), .cs_n(cs_n), .mosi(mosi),
    .read_vld(read_vld), .read_data(read_data)
  );

  spi_reg_checker u_checker (
    .clk(clk), .rst_n(rst_n), .cmd_vld(cmd_vld), .cmd_rdy(cmd_rdy), .cmd_in(cmd_in),
    .cs_n(cs_n), .sclk(sclk), .mosi(mosi), .read_vld(read_vld), .read_data(read_data),
    .test_end(test_end), .n_pass(n_pass), .n_fail(n_fail), .n_done(n_done), .closed(closed)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hb4bc_d35c) : (s >> 1);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] random_byte();
    logic [DATA_WIDTH-1:0] b;
    b = '0;
    for (int i = 0; i < DATA_WIDTH; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      b = {b[DATA_WIDTH-2:0], lfsr_state[0]};
    end
    return b;
  endfunction

  task automatic wait_frames();
    int waited;
    waited = 0;
    while (n_done < sent && !hung)
    begin
      @(posedge clk);
      waited++;
      if (waited > FRAME_TIMEOUT)
      begin
        $display("timeout: only %0d of %0d commands finished their frames", n_done, sent);
        hung = 1'b1;
      end
    end
  endtask

  task automatic apply_entry(input stim_t e);
    int waited;
    logic taken;
    waited = 0;
    taken = 1'b0;
    cmd_in <= {e.rw, e.addr, e.rnd ? random_byte() : e.data};
    cmd_vld <= 1'b1;
    while (!taken && !hung)
    begin
      @(posedge clk);
      waited++;
      taken = cmd_rdy;
      if (!taken && waited > RDY_TIMEOUT)
      begin
        $display("timeout: cmd_rdy stayed low and the command was never taken");
        hung = 1'b1;
      end
    end
    sent++;
    if (!e.burst)
    begin
      cmd_vld <= 1'b0;
      wait_frames();
    end
  endtask

  // slave register model. It decodes frames and shifts read data out on miso.
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      foreach (slave_regs[i])
        slave_regs[i] = '0;
      {slave_sclk_q, slave_pend, slave_data, slave_bits} = '0;
      slave_cs_q = 1'b1;
      miso <= 1'b0;
    end
    else
    begin
      if (slave_cs_q && !cs_n)
      begin
        slave_bits = 0;
        slave_data = slave_pend;
        slave_tx = slave_regs[slave_addr];
        miso <= slave_pend && slave_tx[DATA_WIDTH-1];
        slave_tx = slave_tx << 1;
      end
      if (!slave_sclk_q && sclk && !cs_n)
      begin
        slave_rx = {slave_rx[CMD_WIDTH-2:0], mosi};
        slave_bits++;
      end
      if (slave_sclk_q && !sclk && slave_data)
      begin
        miso <= slave_tx[DATA_WIDTH-1];
        slave_tx = slave_tx << 1;
      end
      if (!slave_cs_q && cs_n)
      begin
        if (slave_bits == CMD_WIDTH && slave_rx.rw)
        begin
          slave_regs[slave_rx.addr] = slave_rx.data;
        end
        slave_pend = (slave_bits == HDR_WIDTH) && !slave_rx[HDR_WIDTH-1];
        slave_addr = slave_rx[ADDR_WIDTH-1:0];
        slave_data = 1'b0;
      end
      slave_cs_q = cs_n;
      slave_sclk_q = sclk;
    end
  end

  initial
  begin
    int waited;
    rst_n = 1'b0;
    cmd_vld = 1'b0;
    cmd_in = '0;
    test_end = 1'b0;
    hung = 1'b0;
    sent = 0;
    waited = 0;
    lfsr_state = 32'h4c95;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    for (int i = 0; i < N_STIM && !hung; i++)
    begin
      apply_entry(stim_tab[i]);
    end
    cmd_vld <= 1'b0;
    wait_frames();
    test_end <= 1'b1;
    while (!closed && !hung && waited < RDY_TIMEOUT)
    begin
      @(posedge clk);
      waited++;
    end
    if (!closed && !hung)
    begin
      $display("timeout: the checker never finished its closing checks");
    end
    $display("tests: %0d passed, %0d failed", n_pass, n_fail);
    if (!hung && closed && n_fail == 0)
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- spi_reg_bridge.f
logic/spi_reg_pkg.sv
logic/spi_cmd_queue.sv
logic/spi_sclk_gen.sv
logic/spi_frame_engine.sv
logic/spi_reg_bridge.sv
verif/spi_reg_checker.sv
verif/spi_reg_bridge_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compiles the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f spi_reg_bridge.f \
  --top-module spi_reg_bridge_tb \
  --Mdir obj_dir -o spi_reg_bridge_sim \
  && ./obj_dir/spi_reg_bridge_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "Regression passed" sim.log \
  && echo "simulation run ok" && exit 0 \
  || { echo "simulation run not ok, see sim.log"; exit 1; }
